//--- project.f
+incdir+verif
common/mem_pkg.sv
hw/word_ram.sv
mem_main/mem_req_queue.sv
mem_main/mem_group_arbiter.sv
mem_main/mem_bank_group.sv
mem_main/mem_main.sv
verif/mem_main_tb.sv

//--- verif/mem_tb_model.svh
`ifndef mem_tb_model_svh
`define mem_tb_model_svh

// shadow copy of every word, by group, bank and row
logic [word_w-1:0] shadow [num_group][words_per_line][bank_depth];

// preload pattern, built from group and word index
function automatic logic [word_w-1:0] fill_word(input int g, input int widx);
  logic [7:0] gb;
  logic [7:0] wb;
  gb = 8'(g);
  wb = 8'(widx);
  return {gb ^ 8'h5a, wb, gb ^ wb ^ 8'hc3, ~wb};
endfunction

// aligned preload line for one row
function automatic logic [line_w-1:0] fill_line(input int g, input int row);
  logic [line_w-1:0] line;
  line = '0;
  for (int k = 0; k < words_per_line; k++) begin
    line[k*word_w +: word_w] = fill_word(g, row * words_per_line + k);
  end
  return line;
endfunction

// word k of a line sits in bank (off + k) mod 4
function automatic int word_bank(input int off, input int k);
  return (off + k) % words_per_line;
endfunction

// one row further once the line runs past bank 3
function automatic int word_row(input int row, input int off, input int k);
  return (row + (off + k) / words_per_line) % bank_depth;
endfunction

function automatic void model_write(input int g, input int row, input int off,
                                    input logic [line_w-1:0] data);
  for (int k = 0; k < words_per_line; k++) begin
    shadow[g][word_bank(off, k)][word_row(row, off, k)] = data[k*word_w +: word_w];
  end
endfunction

// line as a read should return it, word 0 low
function automatic logic [line_w-1:0] expected_line(input int g, input int row, input int off);
  logic [line_w-1:0] line;
  line = '0;
  for (int k = 0; k < words_per_line; k++) begin
    line[k*word_w +: word_w] = shadow[g][word_bank(off, k)][word_row(row, off, k)];
  end
  return line;
endfunction

`endif

//--- verif/mem_main_tb.sv
`timescale 1ns/100ps

module mem_main_tb
  import mem_pkg::*;
();

  logic               clk;
  logic               rst_n;
  logic [num_req-1:0] req_valid;
  mem_req_t           req [num_req];
  logic [num_req-1:0] credit;
  mem_rsp_t           rsp_rt [num_rt];
  mem_rsp_t           rsp_mc;

  // per-source queues from staging through grant to response
  mem_req_t          to_send [num_req][$];
  mem_req_t          pending [num_req][$];
  logic [line_w-1:0] exp_line [num_req][$];
  int                credits [num_req];
  int                sent_cnt [num_req];
  int                pulse_cnt [num_req];

  int    err_cnt;
  int    err_at_start;
  int    test_num;
  int    pass_cnt;
  int    fail_cnt;
  string test_name;

  `include "mem_tb_model.svh"

  mem_main i_mem_main (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .credit    (credit),
    .rsp_rt    (rsp_rt),
    .rsp_mc    (rsp_mc)
  );

  always #4 clk = ~clk;

  function automatic logic [line_w-1:0] rand_line();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // stage one request with random ignored address bits
  task automatic send(input int s, input logic wr, input int g, input int row,
                      input int off, input logic [line_w-1:0] data);
    mem_req_t r;
    r.addr.raw           = $urandom;
    r.addr.fields.group  = grp_w'(g);
    r.addr.fields.row    = row_w'(row);
    r.addr.fields.offset = off_w'(off);
    // mc write flag passes through untouched
    r.write              = wr;
    r.data               = data;
    to_send[s].push_back(r);
  endtask

  // model follows grant order as marked by the credit pulse
  task automatic apply_grant(input int s);
    mem_req_t r;
    int       g;
    int       row;
    int       off;
    if (pending[s].size() == 0) begin
      err_cnt++;
      $display("credit pulse on source %0d with no request outstanding", s);
    end else begin
      r   = pending[s].pop_front();
      g   = r.addr.fields.group;
      row = r.addr.fields.row;
      off = r.addr.fields.offset;
      // mc is always a read
      if (r.write && s < num_rt) begin
        model_write(g, row, off, r.data);
      end else begin
        exp_line[s].push_back(expected_line(g, row, off));
      end
    end
    credits[s]++;
    pulse_cnt[s]++;
    if (credits[s] > queue_depth) begin
      err_cnt++;
      $display("source %0d holds more credits than its queue depth", s);
    end
  endtask

  // one clock of grants then new requests on the falling edge
  task automatic step_cycle();
    mem_req_t r;
    @(negedge clk);
    for (int s = 0; s < num_req; s++) begin
      if (credit[s]) begin
        apply_grant(s);
      end
    end
    for (int s = 0; s < num_req; s++) begin
      if (credits[s] > 0 && to_send[s].size() > 0) begin
        r = to_send[s].pop_front();
        req[s]       = r;
        req_valid[s] = 1'b1;
        credits[s]--;
        sent_cnt[s]++;
        pending[s].push_back(r);
      end else begin
        req_valid[s] = 1'b0;
      end
    end
  endtask

  // first source with work left or -1 when idle
  function automatic int busy_source();
    for (int s = 0; s < num_req; s++) begin
      if (to_send[s].size() + pending[s].size() + exp_line[s].size() > 0) begin
        return s;
      end
    end
    return -1;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $finish;
  endtask

  // bounded run until every source is idle
  task automatic drain();
    int n;
    int s;
    n = 0;
    s = busy_source();
    while (s >= 0) begin
      if (n >= 20000) begin
        abort_run($sformatf("timeout on source %0d: %0d unsent, %0d ungranted, %0d unanswered",
                            s, to_send[s].size(), pending[s].size(), exp_line[s].size()));
      end else begin
        step_cycle();
        n++;
        s = busy_source();
      end
    end
  endtask

  task automatic check_rsp(input int s, input mem_rsp_t r);
    logic [line_w-1:0] e;
    string             name;
    name = (s < num_rt) ? $sformatf("rsp_rt[%0d]", s) : "rsp_mc";
    if (exp_line[s].size() == 0) begin
      err_cnt++;
      $display("response on %s that no read asked for", name);
    end else begin
      e = exp_line[s].pop_front();
      if (r.src != src_w'(s)) begin
        err_cnt++;
        $display("mismatch %s.src expected %0h actual %0h", name, s, r.src);
      end
      if (r.data !== e) begin
        err_cnt++;
        $display("mismatch %s.data expected %h actual %h", name, e, r.data);
      end
    end
  endtask

  // response compare on the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      for (int p = 0; p < num_rt; p++) begin
        if (rsp_rt[p].valid) begin
          check_rsp(p, rsp_rt[p]);
        end
      end
      if (rsp_mc.valid) begin
        check_rsp(num_rt, rsp_mc);
      end
    end
  end

  task automatic begin_test(input string name);
    test_num++;
    test_name    = name;
    err_at_start = err_cnt;
  endtask

  task automatic end_test();
    if (err_cnt == err_at_start) begin
      pass_cnt++;
      $display("test %0d %s: pass", test_num, test_name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: fail, %0d errors", test_num, test_name, err_cnt - err_at_start);
    end
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    req_valid = '0;
    err_cnt   = 0;
    test_num  = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    for (int s = 0; s < num_req; s++) begin
      req[s]       = '0;
      credits[s]   = queue_depth;
      sent_cnt[s]  = 0;
      pulse_cnt[s] = 0;
    end
    void'($urandom(32'h9c1b));
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // preload every row of every group
    for (int g = 0; g < num_group; g++) begin
      for (int row = 0; row < bank_depth; row++) begin
        send((g * bank_depth + row) % num_rt, 1'b1, g, row, 0, fill_line(g, row));
      end
    end
    drain();

    begin_test("aligned write and read");
    send(0, 1'b1, 2, 5, 0, rand_line());
    send(0, 1'b0, 2, 5, 0, '0);
    drain();
    end_test();

    begin_test("unaligned lines, overlap, row wrap");
    for (int o = 1; o < words_per_line; o++) begin
      send(1, 1'b1, 3, 8 + 2 * o, o, rand_line());
      send(1, 1'b0, 3, 8 + 2 * o, o, '0);
    end
    // offset 2 covers the top half of row 20 and bottom of row 21
    send(1, 1'b1, 3, 20, 2, rand_line());
    send(1, 1'b0, 3, 20, 0, '0);
    send(1, 1'b0, 3, 21, 0, '0);
    // row 63 wraps around to row 0
    send(1, 1'b1, 3, 63, 3, rand_line());
    send(1, 1'b0, 3, 63, 0, '0);
    send(1, 1'b0, 3, 0, 0, '0);
    send(1, 1'b0, 3, 63, 3, '0);
    drain();
    end_test();

    begin_test("mc reads with rt traffic");
    for (int p = 0; p < num_rt; p++) begin
      send(p, 1'b1, 4, 30 + p, 0, rand_line());
    end
    drain();
    // mc and rt ports hit group 4 together
    for (int p = 0; p < num_rt; p++) begin
      send(num_rt, 1'b0, 4, 30 + p, 0, '0);
      send(num_rt, 1'b0, 4, 30 + p, 2, '0);
      for (int i = 0; i < 3; i++) begin
        send(p, $urandom_range(0, 1), 4, 30 + $urandom_range(0, 5),
             $urandom_range(0, 3), rand_line());
      end
    end
    drain();
    end_test();

    begin_test("four rt ports into one group");
    for (int p = 0; p < num_rt; p++) begin
      for (int i = 0; i < 6; i++) begin
        send(p, $urandom_range(0, 1), 5, 40 + $urandom_range(0, 7),
             $urandom_range(0, 3), rand_line());
      end
    end
    drain();
    end_test();

    begin_test("credit flow");
    for (int s = 0; s < num_req; s++) begin
      for (int i = 0; i < 8; i++) begin
        send(s, 1'b0, $urandom_range(0, num_group - 1), $urandom_range(0, bank_depth - 1),
             $urandom_range(0, 3), '0);
      end
    end
    drain();
    for (int s = 0; s < num_req; s++) begin
      if (pulse_cnt[s] != sent_cnt[s]) begin
        err_cnt++;
        $display("mismatch credit[%0d] pulses expected %0h actual %0h",
                 s, sent_cnt[s], pulse_cnt[s]);
      end
      if (credits[s] != queue_depth) begin
        err_cnt++;
        $display("mismatch credit[%0d] counter expected %0h actual %0h",
                 s, queue_depth, credits[s]);
      end
    end
    end_test();

    begin_test("random mixed traffic");
    for (int i = 0; i < 300; i++) begin
      send($urandom_range(0, num_req - 1), $urandom_range(0, 1),
           $urandom_range(0, num_group - 1), $urandom_range(0, bank_depth - 1),
           $urandom_range(0, 3), rand_line());
    end
    drain();
    end_test();

    // a few idle cycles catch stray responses
    repeat (8) step_cycle();
    $display("tests run %0d, passed %0d, failed %0d", test_num, pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- mem_main/mem_main.sv
`timescale 1ns/100ps

module mem_main
  import mem_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  // rt ports at 0..num_rt-1, mc port at num_rt
  input  logic [num_req-1:0] req_valid,
  input  mem_req_t           req [num_req],
  output logic [num_req-1:0] credit,
  output mem_rsp_t           rsp_rt [num_rt],
  output mem_rsp_t           rsp_mc
);

  // queue heads toward the arbiter
  logic [num_req-1:0] head_valid;
  mem_req_t           head [num_req];
  logic [num_req-1:0] grant;

  // arbiter to bank groups and back
  bank_cmd_t          cmd [num_group];
  mem_rsp_t           grp_rsp [num_group];

  // one request queue per source
  for (genvar s = 0; s < num_req; s++) begin : g_queue
    mem_req_queue i_mem_req_queue (
      .clk        (clk),
      .rst_n      (rst_n),
      .push       (req_valid[s]),
      .push_req   (req[s]),
      .grant      (grant[s]),
      .head_valid (head_valid[s]),
      .head       (head[s]),
      .credit     (credit[s])
    );
  end

  // mc priority plus per-group round robin, response steering
  mem_group_arbiter i_mem_group_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .head_valid (head_valid),
    .head       (head),
    .grp_rsp    (grp_rsp),
    .grant      (grant),
    .cmd        (cmd),
    .rsp_rt     (rsp_rt),
    .rsp_mc     (rsp_mc)
  );

  // groups run in parallel, one command each per cycle
  for (genvar g = 0; g < num_group; g++) begin : g_group
    mem_bank_group i_mem_bank_group (
      .clk   (clk),
      .rst_n (rst_n),
      .cmd   (cmd[g]),
      .rsp   (grp_rsp[g])
    );
  end

endmodule

//--- mem_main/mem_bank_group.sv
`timescale 1ns/100ps

module mem_bank_group
  import mem_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  bank_cmd_t cmd,
  output mem_rsp_t  rsp
);

  // per-bank ram ports
  logic [row_w-1:0]  bank_row [words_per_line];
  logic [word_w-1:0] bank_din [words_per_line];
  logic [word_w-1:0] bank_dout [words_per_line];
  logic              bank_we;

  // read stage, aligned with the ram read
  logic              rd_vld_q;
  logic [src_w-1:0]  rd_src_q;
  logic [off_w-1:0]  rd_off_q;

  // output stage
  logic [line_w-1:0] line;
  mem_rsp_t          next_rsp;
  mem_rsp_t          rsp_q;
  logic              rsp_vld_q;

  // all four banks take part in every write
  assign bank_we = cmd.valid && cmd.write;

  for (genvar b = 0; b < words_per_line; b++) begin : g_bank
    // line word held by bank b
    logic [off_w-1:0] word_sel;
    assign word_sel = off_w'(b) - cmd.offset;

    // banks below the offset hold the wrapped tail, one row up
    assign bank_row[b] = cmd.row + ((b < cmd.offset) ? row_w'(1) : row_w'(0));
    assign bank_din[b] = cmd.data[word_sel*word_w +: word_w];

    word_ram i_word_ram (
      .clk  (clk),
      .we   (bank_we),
      .addr (bank_row[b]),
      .din  (bank_din[b]),
      .dout (bank_dout[b])
    );
  end

  // undo the rotation, line word k comes from bank offset+k
  always_comb begin : unrotate
    logic [off_w-1:0] src_bank;
    src_bank = rd_off_q;
    for (int k = 0; k < words_per_line; k++) begin
      src_bank = rd_off_q + off_w'(k);
      line[k*word_w +: word_w] = bank_dout[src_bank];
    end
  end

  always_comb begin
    next_rsp.valid = rd_vld_q;
    next_rsp.src   = rd_src_q;
    next_rsp.data  = line;
  end

  // valid pipe, reads only
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_vld_q  <= 1'b0;
      rsp_vld_q <= 1'b0;
    end else begin
      rd_vld_q  <= cmd.valid && !cmd.write;
      rsp_vld_q <= rd_vld_q;
    end
  end

  // tag and offset ride along with the read
  always_ff @(posedge clk) begin
    rd_src_q <= cmd.src;
    rd_off_q <= cmd.offset;
    rsp_q    <= next_rsp;
  end

  always_comb begin
    rsp       = rsp_q;
    rsp.valid = rsp_vld_q;
  end

endmodule

//--- mem_main/mem_group_arbiter.sv
`timescale 1ns/100ps

module mem_group_arbiter
  import mem_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic [num_req-1:0] head_valid,
  input  mem_req_t           head [num_req],
  input  mem_rsp_t           grp_rsp [num_group],
  output logic [num_req-1:0] grant,
  output bank_cmd_t          cmd [num_group],
  output mem_rsp_t           rsp_rt [num_rt],
  output mem_rsp_t           rsp_mc
);

  // one-hot winner per group
  logic [num_req-1:0] win [num_group];
  // responses indexed by source
  mem_rsp_t           rsp_src [num_req];

  for (genvar g = 0; g < num_group; g++) begin : g_grp
    logic [num_req-1:0] hit;
    logic [rt_w-1:0]    rr_ptr;
    logic [src_w-1:0]   win_src;
    bank_cmd_t          next_cmd;
    bank_cmd_t          cmd_q;
    logic               cmd_vld_q;

    // which heads target this group
    always_comb begin
      for (int s = 0; s < num_req; s++) begin
        hit[s] = head_valid[s] && (head[s].addr.fields.group == grp_w'(g));
      end
    end

    // mc first, else first rt hit at or after rr_ptr
    always_comb begin : pick
      logic [rt_w-1:0] idx;
      idx     = rr_ptr;
      win[g]  = '0;
      win_src = '0;
      if (hit[num_rt]) begin
        win[g][num_rt] = 1'b1;
        win_src        = src_w'(num_rt);
      end else begin
        // walk from far to near, nearest hit wins
        for (int k = num_rt - 1; k >= 0; k--) begin
          idx = rr_ptr + rt_w'(k);
          if (hit[idx]) begin
            win[g]      = '0;
            win[g][idx] = 1'b1;
            win_src     = src_w'(idx);
          end
        end
      end
    end

    // mc never writes
    always_comb begin
      next_cmd.valid  = |win[g];
      next_cmd.write  = head[win_src].write && !win[g][num_rt];
      next_cmd.src    = win_src;
      next_cmd.row    = head[win_src].addr.fields.row;
      next_cmd.offset = head[win_src].addr.fields.offset;
      next_cmd.data   = head[win_src].data;
    end

    // pointer moves past the last rt winner
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        rr_ptr    <= '0;
        cmd_vld_q <= 1'b0;
      end else begin
        cmd_vld_q <= next_cmd.valid;
        if (|win[g][num_rt-1:0]) begin
          rr_ptr <= win_src[rt_w-1:0] + 1'b1;
        end
      end
    end

    always_ff @(posedge clk) begin
      cmd_q <= next_cmd;
    end

    always_comb begin
      cmd[g]       = cmd_q;
      cmd[g].valid = cmd_vld_q;
    end
  end

  // a source has one head, so at most one group grants it
  always_comb begin
    grant = '0;
    for (int g = 0; g < num_group; g++) begin
      grant = grant | win[g];
    end
  end

  // route each tagged group response to its source
  always_comb begin
    for (int s = 0; s < num_req; s++) begin
      rsp_src[s] = '0;
      for (int g = 0; g < num_group; g++) begin
        if (grp_rsp[g].valid && (grp_rsp[g].src == src_w'(s))) begin
          rsp_src[s] = grp_rsp[g];
        end
      end
    end
  end

  for (genvar p = 0; p < num_rt; p++) begin : g_rsp_rt
    assign rsp_rt[p] = rsp_src[p];
  end
  assign rsp_mc = rsp_src[num_rt];

endmodule

//--- mem_main/mem_req_queue.sv
`timescale 1ns/100ps

module mem_req_queue
  import mem_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  mem_req_t push_req,
  input  logic     grant,
  output logic     head_valid,
  output mem_req_t head,
  output logic     credit
);

  // entry storage, payload only
  mem_req_t               entry [queue_depth];
  logic [queue_ptr_w-1:0] wr_ptr;
  logic [queue_ptr_w-1:0] rd_ptr;
  logic [queue_cnt_w-1:0] count;
  logic                   pop;

  // head is visible the cycle after the push
  assign head_valid = (count != '0);
  assign head       = entry[rd_ptr];

  // grant only lands on a valid head, guard anyway
  assign pop = grant && head_valid;

  // one credit back to the requester per pop, same cycle as grant
  assign credit = pop;

  // pointers and occupancy
  // no full check, the requester's credits bound the fill level
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == queue_ptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == queue_ptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      count <= count + queue_cnt_w'(push) - queue_cnt_w'(pop);
    end
  end

  // write side
  always_ff @(posedge clk) begin
    if (push) begin
      entry[wr_ptr] <= push_req;
    end
  end

endmodule

//--- hw/word_ram.sv
`timescale 1ns/100ps

module word_ram
  import mem_pkg::*;
(
  input  logic              clk,
  input  logic              we,
  input  logic [row_w-1:0]  addr,
  input  logic [word_w-1:0] din,
  output logic [word_w-1:0] dout
);

  logic [word_w-1:0] mem [bank_depth];

  // read before write, same-cycle read sees old word
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= din;
    end
    dout <= mem[addr];
  end

endmodule

//--- common/mem_pkg.sv
package mem_pkg;

  // port counts, rt ports first then mc
  localparam int num_rt = 4;
  localparam int num_req = num_rt + 1;
  localparam int num_group = 8;

  // line and bank geometry
  localparam int words_per_line = 4;
  localparam int bank_depth = 64;
  localparam int word_w = 32;
  localparam int line_w = words_per_line * word_w;

  // per-port request queue, depth doubles as initial credit count
  localparam int queue_depth = 2;
  localparam int queue_ptr_w = $clog2(queue_depth);
  localparam int queue_cnt_w = $clog2(queue_depth + 1);

  // field widths
  localparam int src_w = 3;
  localparam int rt_w = $clog2(num_rt);
  localparam int grp_w = $clog2(num_group);
  localparam int row_w = $clog2(bank_depth);
  localparam int off_w = $clog2(words_per_line);

  // address decode, byte offset is ignored
  typedef struct packed {
    logic [31-grp_w-row_w-off_w-2:0] unused;
    logic [grp_w-1:0]                group;
    logic [row_w-1:0]                row;
    logic [off_w-1:0]                offset;
    logic [1:0]                      byte_off;
  } mem_addr_fields_t;

  // same address word, raw on the ports, decoded in the arbiter and banks
  typedef union packed {
    logic [31:0]      raw;
    mem_addr_fields_t fields;
  } mem_addr_u;

  // word 0 of a line sits in the low 32 bits
  typedef struct packed {
    logic              write;
    mem_addr_u         addr;
    logic [line_w-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic              valid;
    logic [src_w-1:0]  src;
    logic [line_w-1:0] data;
  } mem_rsp_t;

  // one granted access headed for a bank group
  typedef struct packed {
    logic              valid;
    logic              write;
    logic [src_w-1:0]  src;
    logic [row_w-1:0]  row;
    logic [off_w-1:0]  offset;
    logic [line_w-1:0] data;
  } bank_cmd_t;

endpackage
